// File: hw/axi_pkg.sv
/* AXI4 memory port types */
package axi_pkg;

   // Address and data widths of the memory port
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 64;

   // Wide enough for up to 16 cache ports
   localparam int AXI_ID_W = 4;

   // One byte address on AW or AR
   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

   // One full-width beat on W or R
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // Carries the index of the requesting cache
   typedef logic [AXI_ID_W-1:0] axi_id_t;

endpackage

// File: hw/cache_dma_pkg.sv
/* Cache DMA port types */
package cache_dma_pkg;

   // 32 B cache block, four 64-bit beats
   localparam int BLOCK_OFFSET_W = 5;

   // Block address as issued by the cache, still hashed
   typedef logic [axi_pkg::AXI_ADDR_W-1:0] dma_addr_t;

   // Packet opcode
   typedef enum logic
   {
      DMA_READ  = 1'b0,
      DMA_WRITE = 1'b1
   } dma_op_e;

endpackage

// File: hw/dma_req_arbiter.sv
/* DMA packet arbiter and address unhash */
`timescale 1ns/1ps

module dma_req_arbiter
#(
   parameter int NUM_CACHE = 2,
   localparam int SEL_W = (NUM_CACHE > 1) ? $clog2(NUM_CACHE) : 1
)
(
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,
   input  logic [NUM_CACHE-1:0]                      dma_pkt_v_i,
   input  cache_dma_pkg::dma_addr_t [NUM_CACHE-1:0]  dma_pkt_addr_i,
   input  cache_dma_pkg::dma_op_e [NUM_CACHE-1:0]    dma_pkt_op_i,
   input  logic                                      done_i,
   output logic [NUM_CACHE-1:0]                      dma_pkt_yumi_o,
   output logic                                      req_v_o,
   output cache_dma_pkg::dma_op_e                    req_op_o,
   output axi_pkg::axi_addr_t                        req_addr_o,
   output logic [SEL_W-1:0]                          req_sel_o
);
   import cache_dma_pkg::*;
   import axi_pkg::*;

   localparam int HASH_W = $clog2(NUM_CACHE);

   logic             busy_q;
   logic [SEL_W-1:0] ptr_q;
   logic [SEL_W-1:0] grant;
   logic             grant_v;
   logic             take;

   // Bank select bits XORed with the bits just above them
   function automatic axi_addr_t unhash(input dma_addr_t addr);
      axi_addr_t res;
      res = axi_addr_t'(addr);
      for (int i = 0; i < HASH_W; i++)
      begin
         res[BLOCK_OFFSET_W+i] = addr[BLOCK_OFFSET_W+i] ^ addr[BLOCK_OFFSET_W+HASH_W+i];
      end
      return res;
   endfunction

   // First requester at or after the pointer
   always_comb
   begin
      int idx;
      grant   = ptr_q;
      grant_v = 1'b0;
      for (int i = 0; i < NUM_CACHE; i++)
      begin
         idx = (int'(ptr_q) + i) % NUM_CACHE;
         if (!grant_v && dma_pkt_v_i[idx])
         begin
            grant   = SEL_W'(idx);
            grant_v = 1'b1;
         end
      end
   end

   assign take = !busy_q && grant_v;

   always_comb
   begin
      dma_pkt_yumi_o = '0;
      if (take)
         dma_pkt_yumi_o[grant] = 1'b1;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q <= 1'b0;
         ptr_q  <= '0;
      end
      else if (take)
      begin
         busy_q <= 1'b1;
         ptr_q  <= grant + SEL_W'(1);
      end
      else if (done_i)
         busy_q <= 1'b0;
   end

   // Packet held until the engine finishes
   always_ff @(posedge clk_i)
   begin
      if (take)
      begin
         req_op_o   <= dma_pkt_op_i[grant];
         req_addr_o <= unhash(dma_pkt_addr_i[grant]);
         req_sel_o  <= grant;
      end
   end

   assign req_v_o = busy_q;

endmodule

// File: hw/axi_burst_write.sv
/* AXI4 write burst engine */
`timescale 1ns/1ps

module axi_burst_write
#(
   parameter int NUM_CACHE = 2,
   parameter int BURST_LEN = 4,
   localparam int SEL_W = (NUM_CACHE > 1) ? $clog2(NUM_CACHE) : 1,
   localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1
)
(
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 req_v_i,
   input  cache_dma_pkg::dma_op_e               req_op_i,
   input  axi_pkg::axi_addr_t                   req_addr_i,
   input  logic [SEL_W-1:0]                     req_sel_i,
   input  axi_pkg::axi_data_t [NUM_CACHE-1:0]   dma_data_i,
   input  logic [NUM_CACHE-1:0]                 dma_data_v_i,
   output logic [NUM_CACHE-1:0]                 dma_data_yumi_o,
   output axi_pkg::axi_id_t                     awid_o,
   output axi_pkg::axi_addr_t                   awaddr_o,
   output logic                                 awvalid_o,
   input  logic                                 awready_i,
   output axi_pkg::axi_data_t                   wdata_o,
   output logic                                 wlast_o,
   output logic                                 wvalid_o,
   input  logic                                 wready_i,
   input  logic                                 bvalid_i,
   output logic                                 bready_o,
   output logic                                 done_o
);
   import cache_dma_pkg::*;
   import axi_pkg::*;

   typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_e;

   state_e           state_q;
   state_e           state_d;
   logic [CNT_W-1:0] beat_q;
   logic             w_fire;

   assign awid_o   = axi_id_t'(req_sel_i);
   assign awaddr_o = req_addr_i;
   assign wdata_o  = dma_data_i[req_sel_i];

   // AW goes out in the same cycle the request appears
   assign awvalid_o = (state_q == ADDR) ||
                      (state_q == IDLE && req_v_i && req_op_i == DMA_WRITE);
   assign wvalid_o  = (state_q == DATA) && dma_data_v_i[req_sel_i];
   assign wlast_o   = (state_q == DATA) && (beat_q == CNT_W'(BURST_LEN - 1));
   assign w_fire    = wvalid_o && wready_i;
   assign bready_o  = (state_q == RESP);
   assign done_o    = bready_o && bvalid_i;

   always_comb
   begin
      dma_data_yumi_o = '0;
      dma_data_yumi_o[req_sel_i] = w_fire;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (awvalid_o)
               state_d = awready_i ? DATA : ADDR;
         ADDR:
            if (awready_i)
               state_d = DATA;
         DATA:
            if (w_fire && wlast_o)
               state_d = RESP;
         RESP:
            if (bvalid_i)
               state_d = IDLE;
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= IDLE;
         beat_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (w_fire)
            beat_q <= wlast_o ? '0 : beat_q + 1'b1;
      end
   end

endmodule

// File: hw/axi_burst_read.sv
/* AXI4 read burst engine */
`timescale 1ns/1ps

module axi_burst_read
#(
   parameter int NUM_CACHE = 2,
   parameter int BURST_LEN = 4,
   localparam int SEL_W = (NUM_CACHE > 1) ? $clog2(NUM_CACHE) : 1,
   localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1
)
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    req_v_i,
   input  cache_dma_pkg::dma_op_e  req_op_i,
   input  axi_pkg::axi_addr_t      req_addr_i,
   input  logic [SEL_W-1:0]        req_sel_i,
   output axi_pkg::axi_id_t        arid_o,
   output axi_pkg::axi_addr_t      araddr_o,
   output logic                    arvalid_o,
   input  logic                    arready_i,
   input  axi_pkg::axi_data_t      rdata_i,
   input  logic                    rlast_i,
   input  logic                    rvalid_i,
   output logic                    rready_o,
   input  logic [NUM_CACHE-1:0]    dma_data_ready_i,
   output axi_pkg::axi_data_t      dma_data_o,
   output logic [NUM_CACHE-1:0]    dma_data_v_o,
   output logic                    done_o
);
   import cache_dma_pkg::*;
   import axi_pkg::*;

   typedef enum logic [1:0] {IDLE, ADDR, DATA} state_e;

   state_e           state_q;
   state_e           state_d;
   logic [CNT_W-1:0] beat_q;
   logic             r_fire;
   logic             last_beat;

   assign arid_o     = axi_id_t'(req_sel_i);
   assign araddr_o   = req_addr_i;
   assign dma_data_o = rdata_i;

   assign arvalid_o = (state_q == ADDR) ||
                      (state_q == IDLE && req_v_i && req_op_i == DMA_READ);

   // Requesting cache throttles R directly
   assign rready_o  = (state_q == DATA) && dma_data_ready_i[req_sel_i];
   assign r_fire    = rvalid_i && rready_o;
   // Beat count closes the burst even without rlast
   assign last_beat = rlast_i || (beat_q == CNT_W'(BURST_LEN - 1));
   assign done_o    = r_fire && last_beat;

   always_comb
   begin
      dma_data_v_o = '0;
      dma_data_v_o[req_sel_i] = (state_q == DATA) && rvalid_i;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
            if (arvalid_o)
               state_d = arready_i ? DATA : ADDR;
         ADDR:
            if (arready_i)
               state_d = DATA;
         DATA:
            if (done_o)
               state_d = IDLE;
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= IDLE;
         beat_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (r_fire)
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
      end
   end

endmodule

// File: hw/cache_to_axi.sv
/* Cache DMA to AXI4 burst bridge */
`timescale 1ns/1ps

module cache_to_axi
#(
   parameter int NUM_CACHE = 2,
   parameter int BURST_LEN = 4,
   localparam int SEL_W = (NUM_CACHE > 1) ? $clog2(NUM_CACHE) : 1
)
(
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,

   // Cache DMA ports
   input  logic [NUM_CACHE-1:0]                      dma_pkt_v_i,
   input  cache_dma_pkg::dma_addr_t [NUM_CACHE-1:0]  dma_pkt_addr_i,
   input  cache_dma_pkg::dma_op_e [NUM_CACHE-1:0]    dma_pkt_op_i,
   output logic [NUM_CACHE-1:0]                      dma_pkt_yumi_o,
   input  axi_pkg::axi_data_t [NUM_CACHE-1:0]        dma_data_i,
   input  logic [NUM_CACHE-1:0]                      dma_data_v_i,
   output logic [NUM_CACHE-1:0]                      dma_data_yumi_o,
   output axi_pkg::axi_data_t                        dma_data_o,
   output logic [NUM_CACHE-1:0]                      dma_data_v_o,
   input  logic [NUM_CACHE-1:0]                      dma_data_ready_i,

   // AXI4 memory port
   output axi_pkg::axi_id_t                          awid_o,
   output axi_pkg::axi_addr_t                        awaddr_o,
   output logic                                      awvalid_o,
   input  logic                                      awready_i,
   output axi_pkg::axi_data_t                        wdata_o,
   output logic                                      wlast_o,
   output logic                                      wvalid_o,
   input  logic                                      wready_i,
   input  logic                                      bvalid_i,
   output logic                                      bready_o,
   output axi_pkg::axi_id_t                          arid_o,
   output axi_pkg::axi_addr_t                        araddr_o,
   output logic                                      arvalid_o,
   input  logic                                      arready_i,
   input  axi_pkg::axi_data_t                        rdata_i,
   input  logic                                      rlast_i,
   input  logic                                      rvalid_i,
   output logic                                      rready_o
);
   import cache_dma_pkg::*;
   import axi_pkg::*;

   logic             req_v;
   dma_op_e          req_op;
   axi_addr_t        req_addr;
   logic [SEL_W-1:0] req_sel;
   logic             wr_done;
   logic             rd_done;
   logic             done;

   // Only one burst is ever in flight
   assign done = wr_done | rd_done;

   dma_req_arbiter #(
      .NUM_CACHE(NUM_CACHE)
   ) arb (
      .clk_i,
      .rst_n_i,
      .dma_pkt_v_i,
      .dma_pkt_addr_i,
      .dma_pkt_op_i,
      .done_i(done),
      .dma_pkt_yumi_o,
      .req_v_o(req_v),
      .req_op_o(req_op),
      .req_addr_o(req_addr),
      .req_sel_o(req_sel)
   );

   axi_burst_write #(
      .NUM_CACHE(NUM_CACHE),
      .BURST_LEN(BURST_LEN)
   ) wr (
      .clk_i,
      .rst_n_i,
      .req_v_i(req_v),
      .req_op_i(req_op),
      .req_addr_i(req_addr),
      .req_sel_i(req_sel),
      .dma_data_i,
      .dma_data_v_i,
      .dma_data_yumi_o,
      .awid_o,
      .awaddr_o,
      .awvalid_o,
      .awready_i,
      .wdata_o,
      .wlast_o,
      .wvalid_o,
      .wready_i,
      .bvalid_i,
      .bready_o,
      .done_o(wr_done)
   );

   axi_burst_read #(
      .NUM_CACHE(NUM_CACHE),
      .BURST_LEN(BURST_LEN)
   ) rd (
      .clk_i,
      .rst_n_i,
      .req_v_i(req_v),
      .req_op_i(req_op),
      .req_addr_i(req_addr),
      .req_sel_i(req_sel),
      .arid_o,
      .araddr_o,
      .arvalid_o,
      .arready_i,
      .rdata_i,
      .rlast_i,
      .rvalid_i,
      .rready_o,
      .dma_data_ready_i,
      .dma_data_o,
      .dma_data_v_o,
      .done_o(rd_done)
   );

endmodule

// File: dv/axi_mem_model.sv
/* Stalling AXI4 slave memory */
`timescale 1ns/1ps

module axi_mem_model
#(
   parameter int BURST_LEN = 4,
   parameter int WORDS     = 64
)
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   // Stall per channel, bit 0 AW, 1 W, 2 AR, 3 R
   input  logic [3:0]          stall_i,
   input  axi_pkg::axi_addr_t  awaddr_i,
   input  logic                awvalid_i,
   output logic                awready_o,
   input  axi_pkg::axi_data_t  wdata_i,
   input  logic                wvalid_i,
   output logic                wready_o,
   output logic                bvalid_o,
   input  logic                bready_i,
   input  axi_pkg::axi_addr_t  araddr_i,
   input  logic                arvalid_i,
   output logic                arready_o,
   output axi_pkg::axi_data_t  rdata_o,
   output logic                rlast_o,
   output logic                rvalid_o,
   input  logic                rready_i
);
   import axi_pkg::*;

   typedef enum logic [1:0] {IDLE, WDATA, WRESP, RDATA} state_e;

   axi_data_t words [WORDS];
   state_e    state;
   int        base;
   int        beat;

   assign awready_o = (state == IDLE) && !stall_i[0];
   assign arready_o = (state == IDLE) && !stall_i[2];
   assign wready_o  = (state == WDATA) && !stall_i[1];
   assign rdata_o   = words[(base + beat) % WORDS];
   assign rlast_o   = rvalid_o && (beat == BURST_LEN - 1);

   always @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state    <= IDLE;
         base     <= 0;
         beat     <= 0;
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
               if (awvalid_i && awready_o)
               begin
                  base  <= int'((awaddr_i >> 3) % WORDS);
                  beat  <= 0;
                  state <= WDATA;
               end
               else if (arvalid_i && arready_o)
               begin
                  base  <= int'((araddr_i >> 3) % WORDS);
                  beat  <= 0;
                  state <= RDATA;
               end
            // Burst length is counted here, wlast is left to the testbench
            WDATA:
               if (wvalid_i && wready_o)
               begin
                  words[(base + beat) % WORDS] <= wdata_i;
                  beat <= beat + 1;
                  if (beat == BURST_LEN - 1)
                  begin
                     bvalid_o <= 1'b1;
                     state    <= WRESP;
                  end
               end
            WRESP:
               if (bready_i)
               begin
                  bvalid_o <= 1'b0;
                  state    <= IDLE;
               end
            RDATA:
               if (rvalid_o && rready_i)
               begin
                  rvalid_o <= 1'b0;
                  if (rlast_o)
                     state <= IDLE;
                  else
                     beat <= beat + 1;
               end
               else if (!rvalid_o && !stall_i[3])
                  rvalid_o <= 1'b1;
            default:
               state <= IDLE;
         endcase
      end
   end

endmodule

// File: dv/cache_to_axi_tb.sv
/* Cache to AXI bridge testbench */
`timescale 1ns/1ps

module cache_to_axi_tb;
   import axi_pkg::*;
   import cache_dma_pkg::*;

   localparam int NUM_CACHE = 2;
   localparam int BURST_LEN = 4;
   localparam int REQS      = 100;
   localparam int WORDS     = 64;
   localparam int HASH_W    = $clog2(NUM_CACHE);
   localparam int FLAG_W    = 5 + 2 * NUM_CACHE;
   localparam int LIMIT     = 40000;

   logic                       clk_i;
   logic                       rst_n_i;
   logic [NUM_CACHE-1:0]       dma_pkt_v_i;
   dma_addr_t [NUM_CACHE-1:0]  dma_pkt_addr_i;
   dma_op_e [NUM_CACHE-1:0]    dma_pkt_op_i;
   logic [NUM_CACHE-1:0]       dma_pkt_yumi_o;
   axi_data_t [NUM_CACHE-1:0]  dma_data_i;
   logic [NUM_CACHE-1:0]       dma_data_v_i, dma_data_yumi_o;
   axi_data_t                  dma_data_o;
   logic [NUM_CACHE-1:0]       dma_data_v_o, dma_data_ready_i;
   axi_id_t                    awid_o, arid_o;
   axi_addr_t                  awaddr_o, araddr_o;
   axi_data_t                  wdata_o, rdata_i;
   logic                       awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
   logic                       bvalid_i, bready_o, arvalid_o, arready_i;
   logic                       rlast_i, rvalid_i, rready_o;
   logic [3:0]                 stall;

   // Request stream of each cache
   dma_op_e     req_op   [NUM_CACHE][REQS];
   dma_addr_t   req_addr [NUM_CACHE][REQS];
   axi_data_t   req_data [NUM_CACHE][REQS][BURST_LEN];
   int          head     [NUM_CACHE];
   axi_data_t   model_mem [WORDS];

   // Burst in flight
   axi_data_t   cur_data [BURST_LEN];
   dma_op_e     cur_op;
   axi_addr_t   cur_addr;
   int          cur_lane, last_grant, fed, w_seen, r_seen, done_cnt;
   logic        busy, data_hold;
   int unsigned lcg = 15;

   cache_to_axi #(
      .NUM_CACHE(NUM_CACHE),
      .BURST_LEN(BURST_LEN)
   ) DUT (.*);

   axi_mem_model #(
      .BURST_LEN(BURST_LEN),
      .WORDS(WORDS)
   ) mem (
      .clk_i(clk_i),
      .rst_n_i(rst_n_i),
      .stall_i(stall),
      .awaddr_i(awaddr_o),
      .awvalid_i(awvalid_o),
      .awready_o(awready_i),
      .wdata_i(wdata_o),
      .wvalid_i(wvalid_o),
      .wready_o(wready_i),
      .bvalid_o(bvalid_i),
      .bready_i(bready_o),
      .araddr_i(araddr_o),
      .arvalid_i(arvalid_o),
      .arready_o(arready_i),
      .rdata_o(rdata_i),
      .rlast_o(rlast_i),
      .rvalid_o(rvalid_i),
      .rready_i(rready_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [15:0] next_rand();
      lcg = lcg * 32'd1103515245 + 32'd12345;
      return lcg[30:15];
   endfunction

   function automatic axi_data_t rand_beat();
      axi_data_t d;
      d = '0;
      for (int i = 0; i < 4; i++)
         d = {d[47:0], next_rand()};
      return d;
   endfunction

   // Bank bits XOR the bits just above them
   function automatic axi_addr_t unhashed(input dma_addr_t a);
      axi_addr_t r;
      r = a;
      for (int i = 0; i < HASH_W; i++)
         r[BLOCK_OFFSET_W+i] = a[BLOCK_OFFSET_W+i] ^ a[BLOCK_OFFSET_W+HASH_W+i];
      return r;
   endfunction

   function automatic int word_index(input axi_addr_t a);
      return int'((a >> 3) % WORDS);
   endfunction

   function automatic axi_data_t fill_word(input int idx);
      axi_addr_t a;
      a = axi_addr_t'(idx * 8);
      return {a ^ 32'h5A5A_0000, ~a};
   endfunction

   function automatic int rr_winner(input logic [NUM_CACHE-1:0] v, input int last);
      for (int i = 1; i <= NUM_CACHE; i++)
      begin
         if (v[(last + i) % NUM_CACHE])
            return (last + i) % NUM_CACHE;
      end
      return -1;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_flags(input string name, input logic [FLAG_W-1:0] exp,
                              input logic [FLAG_W-1:0] act);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic check_idle();
      check_flags("reset_idle", '0, {awvalid_o, wvalid_o, arvalid_o, bready_o, rready_o,
                                     dma_pkt_yumi_o, dma_data_v_o});
   endtask

   task automatic drive_inputs();
      logic [15:0] r;
      r = next_rand();
      for (int k = 0; k < NUM_CACHE; k++)
      begin
         dma_pkt_v_i[k] = head[k] < REQS;
         if (dma_pkt_v_i[k])
         begin
            dma_pkt_op_i[k]   = req_op[k][head[k]];
            dma_pkt_addr_i[k] = req_addr[k][head[k]];
         end
         dma_data_i[k]       = rand_beat();
         dma_data_ready_i[k] = r[k];
      end
      // A write beat stays offered until it is taken
      data_hold = busy && cur_op == DMA_WRITE && fed < BURST_LEN && (data_hold || r[8]);
      dma_data_v_i = '0;
      dma_data_v_i[cur_lane] = data_hold;
      if (data_hold)
         dma_data_i[cur_lane] = cur_data[fed];
      stall = r[7:4];
   endtask

   task automatic observe_cycle();
      int idx;
      for (int k = 0; k < NUM_CACHE; k++)
      begin
         if (dma_pkt_yumi_o[k])
         begin
            if (busy)
               abort_run("packet accepted while a burst was still in flight");
            check_id("rr_grant", axi_id_t'(rr_winner(dma_pkt_v_i, last_grant)), axi_id_t'(k));
            last_grant = k;
            cur_lane   = k;
            cur_op     = req_op[k][head[k]];
            cur_addr   = unhashed(req_addr[k][head[k]]);
            idx        = word_index(cur_addr);
            for (int b = 0; b < BURST_LEN; b++)
            begin
               if (cur_op == DMA_WRITE)
               begin
                  cur_data[b] = req_data[k][head[k]][b];
                  model_mem[(idx + b) % WORDS] = cur_data[b];
               end
               else
                  cur_data[b] = model_mem[(idx + b) % WORDS];
            end
            head[k]++;
            busy   = 1'b1;
            fed    = 0;
            w_seen = 0;
            r_seen = 0;
         end
      end
      if (awvalid_o && awready_i)
      begin
         check_addr("aw_addr", cur_addr, awaddr_o);
         check_id("aw_id", axi_id_t'(cur_lane), awid_o);
      end
      if (arvalid_o && arready_i)
      begin
         check_addr("ar_addr", cur_addr, araddr_o);
         check_id("ar_id", axi_id_t'(cur_lane), arid_o);
      end
      if (dma_data_yumi_o != '0)
      begin
         check_flags("data_yumi", FLAG_W'(1) << cur_lane, FLAG_W'(dma_data_yumi_o));
         fed++;
         data_hold = 1'b0;
      end
      if (wvalid_o && wready_i)
      begin
         check_data("w_data", cur_data[w_seen], wdata_o);
         check_flags("w_last", FLAG_W'(w_seen == BURST_LEN - 1), FLAG_W'(wlast_o));
         w_seen++;
      end
      if (bvalid_i && bready_o)
      begin
         if (w_seen != BURST_LEN)
            abort_run("write response arrived before the whole burst was sent");
         busy = 1'b0;
         done_cnt++;
      end
      for (int k = 0; k < NUM_CACHE; k++)
      begin
         if (dma_data_v_o[k] && dma_data_ready_i[k])
         begin
            check_id("r_lane", axi_id_t'(cur_lane), axi_id_t'(k));
            check_data("r_data", cur_data[r_seen], dma_data_o);
            r_seen++;
            if (r_seen == BURST_LEN)
            begin
               busy = 1'b0;
               done_cnt++;
            end
         end
      end
   endtask

   initial
   begin
      logic [15:0] r;
      int          cycles;
      rst_n_i          = 1'b0;
      dma_pkt_v_i      = '0;
      dma_pkt_addr_i   = '0;
      dma_data_i       = '0;
      dma_data_v_i     = '0;
      dma_data_ready_i = '0;
      stall            = '0;
      cur_lane         = 0;
      last_grant       = NUM_CACHE - 1;
      busy             = 1'b0;
      data_hold        = 1'b0;
      fed              = 0;
      done_cnt         = 0;
      for (int k = 0; k < NUM_CACHE; k++)
      begin
         dma_pkt_op_i[k] = DMA_READ;
         head[k]         = 0;
         for (int n = 0; n < REQS; n++)
         begin
            r = next_rand();
            req_op[k][n]   = r[0] ? DMA_WRITE : DMA_READ;
            req_addr[k][n] = 32'h8000_0000 | (dma_addr_t'(r[4:1]) << BLOCK_OFFSET_W);
            for (int b = 0; b < BURST_LEN; b++)
               req_data[k][n][b] = rand_beat();
         end
      end
      for (int i = 0; i < WORDS; i++)
      begin
         model_mem[i] = fill_word(i);
         mem.words[i] = fill_word(i);
      end

      repeat (8) @(posedge clk_i);
      #1 rst_n_i = 1'b1;
      for (int c = 0; c < 8; c++)
      begin
         @(negedge clk_i);
         check_idle();
      end

      cycles = 0;
      while (done_cnt < NUM_CACHE * REQS)
      begin
         @(posedge clk_i);
         #1 drive_inputs();
         @(negedge clk_i);
         observe_cycle();
         cycles++;
         if (cycles > LIMIT)
            abort_run($sformatf("timeout after %0d cycles, only %0d of %0d requests done",
                                cycles, done_cnt, NUM_CACHE * REQS));
      end

      for (int i = 0; i < WORDS; i++)
         check_data("final_mem", model_mem[i], mem.words[i]);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: cache_to_axi.f
hw/axi_pkg.sv
hw/cache_dma_pkg.sv
hw/dma_req_arbiter.sv
hw/axi_burst_write.sv
hw/axi_burst_read.sv
hw/cache_to_axi.sv
dv/axi_mem_model.sv
dv/cache_to_axi_tb.sv
